/* source/matrix_consts.svh */
`ifndef MATRIX_CONSTS_SVH
`define MATRIX_CONSTS_SVH

// Panel size kept small for simulation
`define PANEL_WIDTH 16
`define PANEL_HALFHEIGHT 4          // Rows per half
`define PANEL_HEIGHT 8              // Both halves shift out together

`define FRAME_WORDS (`PANEL_WIDTH * `PANEL_HEIGHT)

// Binary-coded modulation
`define PLANE_COUNT 6
`define PLANE_BASE_TICKS 2          // Plane k is lit for this shifted left by k

// Shift timing
`define COLUMN_SLOT_TICKS 4         // Clocks per shifted column

`endif

/* source/matrix_pkg.sv */
`include "matrix_consts.svh"

package matrix_pkg;

    // RGB565 pixel as stored in the frame store
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_rgb565_t;

    typedef logic [2:0] rgb_bits_t;                          // Bit 0 red, 1 green, 2 blue

    // One-hot plane or a set of enabled planes
    typedef logic [`PLANE_COUNT-1:0] plane_mask_t;

    typedef logic [$clog2(`PANEL_WIDTH)-1:0] column_t;
    typedef logic [$clog2(`PANEL_HALFHEIGHT)-1:0] half_row_t;
    typedef logic [$clog2(`FRAME_WORDS)-1:0] pixel_addr_t;   // Row * width + column

endpackage

/* source/pixel_write.sv */
`timescale 1ns/1ns
`include "matrix_consts.svh"

module pixel_write import matrix_pkg::*; (
    input  logic          clk_root,
    input  logic          reset,
    input  logic [7:0]    host_data,
    input  logic          host_valid,
    output pixel_addr_t   wr_addr,
    output pixel_rgb565_t wr_data,
    output logic          wr_en,
    output rgb_bits_t     rgb_enable,
    output plane_mask_t   brightness_enable
);

    localparam logic [7:0] CMD_LOAD = "L";
    localparam logic [7:0] CMD_RGB_ENABLE = "E";
    localparam logic [7:0] CMD_PLANE_ENABLE = "B";
    localparam pixel_addr_t LAST_ADDR = pixel_addr_t'(`FRAME_WORDS - 1);

    typedef enum logic [2:0] {
        WAIT_CMD,
        PIXEL_LOW,
        PIXEL_HIGH,
        SET_RGB,
        SET_PLANES
    } cmd_state_t;

    cmd_state_t  state;
    pixel_addr_t load_addr;     // Next pixel slot in raster order
    logic [7:0]  low_byte;

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state <= WAIT_CMD;
            load_addr <= '0;
            wr_en <= 1'b0;
            rgb_enable <= '1;
            brightness_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (host_valid) begin
                case (state)
                    WAIT_CMD: begin
                        case (host_data)
                            CMD_LOAD: begin
                                state <= PIXEL_LOW;
                                load_addr <= '0;
                            end
                            CMD_RGB_ENABLE: state <= SET_RGB;
                            CMD_PLANE_ENABLE: state <= SET_PLANES;
                            default: state <= WAIT_CMD;     // Junk byte dropped
                        endcase
                    end
                    PIXEL_LOW: state <= PIXEL_HIGH;
                    PIXEL_HIGH: begin
                        wr_en <= 1'b1;
                        load_addr <= load_addr + 1'b1;
                        // Load ends once the whole frame is stored
                        state <= (load_addr == LAST_ADDR) ? WAIT_CMD : PIXEL_LOW;
                    end
                    SET_RGB: begin
                        rgb_enable <= host_data[2:0];
                        state <= WAIT_CMD;
                    end
                    SET_PLANES: begin
                        brightness_enable <= host_data[`PLANE_COUNT-1:0];
                        state <= WAIT_CMD;
                    end
                    default: state <= WAIT_CMD;
                endcase
            end
        end
    end

    // Byte pairs assemble into one RGB565 word, low byte first
    always_ff @(posedge clk_root) begin
        if (host_valid && state == PIXEL_LOW) begin
            low_byte <= host_data;
        end
        if (host_valid && state == PIXEL_HIGH) begin
            wr_data <= {host_data, low_byte};
            wr_addr <= load_addr;
        end
    end

endmodule

/* source/frame_store.sv */
`timescale 1ns/1ns
`include "matrix_consts.svh"

module frame_store import matrix_pkg::*; (
    input  logic          clk_root,
    input  pixel_addr_t   wr_addr,
    input  pixel_rgb565_t wr_data,
    input  logic          wr_en,
    input  pixel_addr_t   rd_addr,
    output pixel_rgb565_t rd_data
);

    // One word per pixel
    pixel_rgb565_t mem [`FRAME_WORDS];

    // Host side write port
    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Display side read port
    // A read of the address being written returns the old word
    always_ff @(posedge clk_root) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* source/matrix_scan.sv */
`timescale 1ns/1ns
`include "matrix_consts.svh"

module matrix_scan import matrix_pkg::*; (
    input  logic        clk_root,
    input  logic        reset,
    output logic        column_start,
    output column_t     column_address,
    output half_row_t   shift_row,
    output plane_mask_t plane,
    output logic        clk_pixel,
    output logic        row_latch,
    output logic        output_enable,
    output half_row_t   row_address
);

    localparam int PHASE_W = $clog2(`COLUMN_SLOT_TICKS);
    localparam int SLOT_W = $clog2(`PANEL_WIDTH) + 1;
    localparam int PLANE_W = $clog2(`PLANE_COUNT);
    localparam int ON_W = $clog2(`PLANE_BASE_TICKS << (`PLANE_COUNT - 1)) + 1;

    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(`COLUMN_SLOT_TICKS - 1);
    localparam logic [SLOT_W-1:0] DRAIN_SLOT = SLOT_W'(`PANEL_WIDTH);
    localparam logic [PLANE_W-1:0] LAST_PLANE = PLANE_W'(`PLANE_COUNT - 1);
    localparam half_row_t LAST_ROW = half_row_t'(`PANEL_HALFHEIGHT - 1);

    typedef enum logic [1:0] {
        SHIFT,
        LATCH,
        DISPLAY
    } scan_state_t;

    scan_state_t        state;
    logic [PHASE_W-1:0] phase;          // Clock within a column slot
    logic [SLOT_W-1:0]  slot;           // One slot per column plus a drain slot
    logic [PLANE_W-1:0] plane_index;
    logic [ON_W-1:0]    on_count;       // Remaining display cycles
    logic               fetch_slot;
    logic               pixel_slot;

    // Split output trails its read by one slot, so the last column drains in an extra slot
    assign fetch_slot = (slot != DRAIN_SLOT);
    assign pixel_slot = (slot != '0);

    assign plane = plane_mask_t'(1) << plane_index;

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state <= SHIFT;
            phase <= '0;
            slot <= '0;
            plane_index <= '0;
            shift_row <= '0;
            on_count <= '0;
        end else begin
            case (state)
                SHIFT: begin
                    if (phase == LAST_PHASE) begin
                        phase <= '0;
                        if (slot == DRAIN_SLOT) begin
                            slot <= '0;
                            state <= LATCH;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                LATCH: begin
                    // Binary-weighted on-time for this plane
                    on_count <= ON_W'(`PLANE_BASE_TICKS << plane_index) - 1'b1;
                    state <= DISPLAY;
                end
                DISPLAY: begin
                    if (on_count == '0) begin
                        state <= SHIFT;
                        if (plane_index == LAST_PLANE) begin
                            plane_index <= '0;
                            shift_row <= (shift_row == LAST_ROW) ? '0 : shift_row + 1'b1;
                        end else begin
                            plane_index <= plane_index + 1'b1;
                        end
                    end else begin
                        on_count <= on_count - 1'b1;
                    end
                end
                default: state <= SHIFT;
            endcase
        end
    end

    // Strobes registered from the counters so all of them share one cycle of lag
    always_ff @(posedge clk_root) begin
        if (reset) begin
            column_start <= 1'b0;
            column_address <= '0;
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
            output_enable <= 1'b0;
            row_address <= '0;
        end else begin
            column_start <= (state == SHIFT) && (phase == '0) && fetch_slot;
            column_address <= slot[SLOT_W-2:0];
            clk_pixel <= (state == SHIFT) && (phase == LAST_PHASE) && pixel_slot;
            row_latch <= (state == LATCH);
            output_enable <= (state == DISPLAY);  // Dark while shifting
            if (state == LATCH) begin
                row_address <= shift_row;         // Row switches with the latch
            end
        end
    end

endmodule

/* source/framebuffer_fetch.sv */
`timescale 1ns/1ns
`include "matrix_consts.svh"

module framebuffer_fetch import matrix_pkg::*; (
    input  logic          clk_root,
    input  logic          reset,
    input  logic          column_start,
    input  column_t       column_address,
    input  half_row_t     shift_row,
    output pixel_addr_t   rd_addr,
    input  pixel_rgb565_t rd_data,
    output pixel_rgb565_t pixel_top,
    output pixel_rgb565_t pixel_bottom
);

    // Bottom half starts this many words after the top half
    localparam pixel_addr_t HALF_OFFSET = pixel_addr_t'(`PANEL_HALFHEIGHT * `PANEL_WIDTH);

    pixel_addr_t   top_addr;
    pixel_addr_t   bottom_addr;
    logic          read_bottom;     // Slot cycle 1
    logic          word_ready;      // Slot cycle 2
    pixel_rgb565_t top_hold;

    // Row times width plus column, the width being a power of two
    assign top_addr = pixel_addr_t'({shift_row, column_address});

    assign rd_addr = read_bottom ? bottom_addr : top_addr;

    always_ff @(posedge clk_root) begin
        if (reset) begin
            read_bottom <= 1'b0;
            word_ready <= 1'b0;
        end else begin
            read_bottom <= column_start;
            word_ready <= read_bottom;
        end
    end

    always_ff @(posedge clk_root) begin
        if (column_start) begin
            bottom_addr <= top_addr + HALF_OFFSET;
        end
        if (read_bottom) begin
            top_hold <= rd_data;        // Top word from the slot cycle 0 read
        end
        // Both halves update together
        if (word_ready) begin
            pixel_top <= top_hold;
            pixel_bottom <= rd_data;
        end
    end

endmodule

/* source/pixel_split.sv */
`timescale 1ns/1ns

module pixel_split import matrix_pkg::*; (
    input  logic          clk_root,
    input  pixel_rgb565_t pixel,
    input  plane_mask_t   plane,
    input  rgb_bits_t     rgb_enable,
    input  plane_mask_t   brightness_enable,
    output rgb_bits_t     rgb
);

    logic [5:0] red_wide;
    logic [5:0] green_wide;
    logic [5:0] blue_wide;
    logic       plane_on;
    rgb_bits_t  plane_bits;

    // 5-bit channels reuse their MSB as the new LSB
    assign red_wide = {pixel.red, pixel.red[4]};
    assign green_wide = pixel.green;
    assign blue_wide = {pixel.blue, pixel.blue[4]};

    assign plane_on = |(plane & brightness_enable);
    assign plane_bits = {|(blue_wide & plane), |(green_wide & plane), |(red_wide & plane)};

    always_ff @(posedge clk_root) begin
        rgb <= plane_bits & rgb_enable & {3{plane_on}};
    end

endmodule

/* source/led_matrix_top.sv */
`timescale 1ns/1ns

module led_matrix_top import matrix_pkg::*; (
    input  logic       clk_root,
    input  logic       reset,
    input  logic [7:0] host_data,
    input  logic       host_valid,
    output rgb_bits_t  rgb_top,
    output rgb_bits_t  rgb_bottom,
    output half_row_t  row_address,
    output logic       clk_pixel,
    output logic       row_latch,
    output logic       output_enable
);

    // Host write side
    pixel_addr_t   wr_addr;
    pixel_rgb565_t wr_data;
    logic          wr_en;
    rgb_bits_t     rgb_enable;
    plane_mask_t   brightness_enable;

    // Display read side
    pixel_addr_t   rd_addr;
    pixel_rgb565_t rd_data;
    logic          column_start;
    column_t       column_address;
    half_row_t     shift_row;
    plane_mask_t   plane;
    pixel_rgb565_t pixel_top;
    pixel_rgb565_t pixel_bottom;

    pixel_write u_pixel_write (
        .clk_root(clk_root),
        .reset(reset),
        .host_data(host_data),
        .host_valid(host_valid),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .wr_en(wr_en),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable)
    );

    frame_store u_frame_store (
        .clk_root(clk_root),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .wr_en(wr_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    matrix_scan u_matrix_scan (
        .clk_root(clk_root),
        .reset(reset),
        .column_start(column_start),
        .column_address(column_address),
        .shift_row(shift_row),
        .plane(plane),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_address(row_address)
    );

    framebuffer_fetch u_fetch (
        .clk_root(clk_root),
        .reset(reset),
        .column_start(column_start),
        .column_address(column_address),
        .shift_row(shift_row),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .pixel_top(pixel_top),
        .pixel_bottom(pixel_bottom)
    );

    // Both halves share the plane and enables
    pixel_split u_split_top (
        .clk_root(clk_root),
        .pixel(pixel_top),
        .plane(plane),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .rgb(rgb_top)
    );

    pixel_split u_split_bottom (
        .clk_root(clk_root),
        .pixel(pixel_bottom),
        .plane(plane),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .rgb(rgb_bottom)
    );

endmodule

/* bench/led_matrix_tb.sv */
`timescale 1ns/1ns
`include "matrix_consts.svh"

module led_matrix_tb import matrix_pkg::*; ();

    localparam int KEEP_FRAME = 0;      // No load, frame from the previous test
    localparam int RANDOM_FRAME = 1;
    localparam int ADDR_FRAME = 2;
    localparam int N_TESTS = 5;
    localparam int JUNK_BYTES = 8;
    localparam int LATCHES_PER_FRAME = `PLANE_COUNT * `PANEL_HALFHEIGHT;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    // One shift is a slot per column plus one drain slot, then latch and display
    localparam int ROW_CYCLES = `PLANE_COUNT * ((`PANEL_WIDTH + 1) * `COLUMN_SLOT_TICKS + 1)
                                + `PLANE_BASE_TICKS * ((1 << `PLANE_COUNT) - 1);
    localparam int FRAME_CYCLES = ROW_CYCLES * `PANEL_HALFHEIGHT;
    localparam int LOAD_CYCLES = 2 * `FRAME_WORDS + JUNK_BYTES + 6;
    localparam int TIMEOUT_CYCLES = N_TESTS * (LOAD_CYCLES + 2 * FRAME_CYCLES) + FRAME_CYCLES;

    typedef struct {
        string name;
        int    pattern;
        int    rgb_en;      // -1 skips the command
        int    plane_en;
        bit    junk;
    } test_row_t;

    test_row_t tests [N_TESTS] = '{
        '{"addr_fill", ADDR_FRAME, -1, -1, 1'b0},
        '{"random_full", RANDOM_FRAME, 8'h07, 8'h3f, 1'b0},
        '{"rgb_partial", RANDOM_FRAME, 8'h05, -1, 1'b0},
        '{"plane_partial", KEEP_FRAME, 8'h07, 8'h2d, 1'b0},
        '{"junk_keep", KEEP_FRAME, -1, -1, 1'b1}
    };

    logic       clk_root = 1'b0;
    logic       reset;
    logic [7:0] host_data;
    logic       host_valid;
    rgb_bits_t  rgb_top;
    rgb_bits_t  rgb_bottom;
    half_row_t  row_address;
    logic       clk_pixel;
    logic       row_latch;
    logic       output_enable;

    logic [15:0] ref_frame [`FRAME_WORDS];
    rgb_bits_t   exp_rgb_en;
    plane_mask_t exp_plane_en;
    logic [31:0] lfsr;
    string       test_name;
    int          latch_total;
    int          col_count;
    int          oe_count;
    int          check_from;     // First latch index of the checked frame
    int          cycle_count;
    logic [3*`PANEL_WIDTH-1:0] cap_top;
    logic [3*`PANEL_WIDTH-1:0] cap_bottom;

    led_matrix_top u_dut (
        .clk_root(clk_root),
        .reset(reset),
        .host_data(host_data),
        .host_valid(host_valid),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .row_address(row_address),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable)
    );

    always #2 clk_root = ~clk_root;

    task automatic check_value(input string label, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %0h actual %0h", test_name, label, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Panel bits for one pixel on one plane
    function automatic rgb_bits_t expected_bits(input logic [15:0] pixel, input int plane_idx);
        logic [5:0] red;
        logic [5:0] green;
        logic [5:0] blue;
        rgb_bits_t  bits;
        red = {pixel[15:11], pixel[15]};
        green = pixel[10:5];
        blue = {pixel[4:0], pixel[4]};
        bits = {blue[plane_idx], green[plane_idx], red[plane_idx]};
        if (!exp_plane_en[plane_idx]) begin
            bits = '0;
        end
        return bits & exp_rgb_en;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        @(posedge clk_root);
        host_data <= value;
        host_valid <= 1'b1;
    endtask

    task automatic send_junk();
        logic [7:0] value;
        for (int i = 0; i < JUNK_BYTES; i++) begin
            value = 8'(random_bits(8));
            if (value == "L" || value == "E" || value == "B") begin
                value = value ^ 8'h80;      // Keep it out of the command set
            end
            send_byte(value);
        end
    endtask

    task automatic load_frame(input int pattern);
        logic [15:0] word;
        logic [6:0]  addr;
        send_byte("L");
        for (int i = 0; i < `FRAME_WORDS; i++) begin
            addr = 7'(i);
            if (pattern == RANDOM_FRAME) begin
                word = random_bits(16);
            end else begin
                word = {addr, ~addr, addr[1:0]};
            end
            ref_frame[i] = word;
            send_byte(word[7:0]);           // Low byte first
            send_byte(word[15:8]);
        end
    endtask

    task automatic run_test(input int idx);
        int start_count;
        test_name = tests[idx].name;
        if (tests[idx].junk) begin
            send_junk();
        end
        if (tests[idx].pattern != KEEP_FRAME) begin
            load_frame(tests[idx].pattern);
        end
        if (tests[idx].rgb_en >= 0) begin
            send_byte("E");
            send_byte(8'(tests[idx].rgb_en));
            exp_rgb_en = tests[idx].rgb_en[2:0];
        end
        if (tests[idx].plane_en >= 0) begin
            send_byte("B");
            send_byte(8'(tests[idx].plane_en));
            exp_plane_en = tests[idx].plane_en[5:0];
        end
        @(posedge clk_root);
        host_valid <= 1'b0;
        // One latch first, so the next shift fetches the new data
        start_count = latch_total;
        wait (latch_total > start_count);
        check_from = ((latch_total + LATCHES_PER_FRAME - 1) / LATCHES_PER_FRAME)
                     * LATCHES_PER_FRAME;
        wait (latch_total >= check_from + LATCHES_PER_FRAME);
        check_from = -1;
    endtask

    // Runs on every latch
    task automatic latch_seen();
        int plane_idx;
        int row;
        int prev_plane;
        logic [3*`PANEL_WIDTH-1:0] exp_top;
        logic [3*`PANEL_WIDTH-1:0] exp_bottom;
        plane_idx = latch_total % `PLANE_COUNT;
        row = (latch_total / `PLANE_COUNT) % `PANEL_HALFHEIGHT;
        prev_plane = (latch_total + `PLANE_COUNT - 1) % `PLANE_COUNT;
        check_value("row_address", row, row_address);
        check_value("column_count", `PANEL_WIDTH, col_count);
        if (latch_total > 0) begin
            check_value("oe_width", `PLANE_BASE_TICKS << prev_plane, oe_count);
        end
        if (check_from >= 0 && latch_total >= check_from &&
            latch_total < check_from + LATCHES_PER_FRAME) begin
            for (int col = 0; col < `PANEL_WIDTH; col++) begin
                exp_top[col*3 +: 3] = expected_bits(ref_frame[row*`PANEL_WIDTH + col], plane_idx);
                exp_bottom[col*3 +: 3] =
                    expected_bits(ref_frame[(row + `PANEL_HALFHEIGHT)*`PANEL_WIDTH + col], plane_idx);
            end
            check_value($sformatf("row %0d plane %0d top", row, plane_idx), exp_top, cap_top);
            check_value($sformatf("row %0d plane %0d bottom", row, plane_idx),
                        exp_bottom, cap_bottom);
        end
        oe_count = 0;
        col_count = 0;
        latch_total++;
    endtask

    // Sampled mid-cycle, away from the DUT's clock edge
    always @(negedge clk_root) begin
        if (reset) begin
            latch_total = 0;
            col_count = 0;
            oe_count = 0;
        end else begin
            if (output_enable) begin
                oe_count++;
            end
            if (clk_pixel) begin
                if (col_count < `PANEL_WIDTH) begin
                    cap_top[col_count*3 +: 3] = rgb_top;
                    cap_bottom[col_count*3 +: 3] = rgb_bottom;
                end
                col_count++;
            end
            if (row_latch) begin
                latch_seen();
            end
        end
    end

    always @(posedge clk_root) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1);
        end
    end

    initial begin
        reset = 1'b1;
        host_data = '0;
        host_valid = 1'b0;
        lfsr = 32'hbe3dfb3f;
        exp_rgb_en = 3'b111;
        exp_plane_en = '1;
        check_from = -1;
        cycle_count = 0;
        test_name = "reset_idle";
        repeat (10) @(posedge clk_root);
        reset <= 1'b0;
        // Outputs stay quiet through the first column slot
        repeat (`COLUMN_SLOT_TICKS) begin
            @(negedge clk_root);
            check_value("output_enable", 0, output_enable);
            check_value("row_latch", 0, row_latch);
            check_value("clk_pixel", 0, clk_pixel);
            check_value("row_address", 0, row_address);
        end
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("No errors");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+source
source/matrix_pkg.sv
source/pixel_write.sv
source/frame_store.sv
source/matrix_scan.sv
source/framebuffer_fetch.sv
source/pixel_split.sv
source/led_matrix_top.sv
bench/led_matrix_tb.sv

/* Bender.yml */
package:
  name: led_matrix

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/matrix_pkg.sv
      - source/pixel_write.sv
      - source/frame_store.sv
      - source/matrix_scan.sv
      - source/framebuffer_fetch.sv
      - source/pixel_split.sv
      - source/led_matrix_top.sv
  - target: test
    files:
      - bench/led_matrix_tb.sv
